// ==== dv/snake_tests.dat ====
# name btn ticks next_x next_y | expected head_x head_y score length fruit_x fruit_y start over
# btn 0 none, 1 right, 2 left, 3 both at once
start_down   1 10  0  0   8 50  0  6  18 50  1  0
turn_left    2  1  0  0   9 50  0  6  18 50  1  0
both_cancel  3  1  0  0  10 50  0  6  18 50  1  0
eat_fruit    0  8 30 20  18 50  1  7  30 20  1  0
wall_up      2 51  0  0  18  0  1  7  30 20  0  1
restart      1  0  0  0   8 40  0  6  18 50  0  0
loop_start   1  1  0  0   8 41  0  6  18 50  1  0
loop_turn    1  1  0  0   7 41  0  6  18 50  1  0
self_hit     1  1  0  0   7 40  0  6  18 50  0  1

// ==== snake_game_top.f ====
+incdir+include
hdl/snake_geometry_pkg.sv
hdl/snake_control_pkg.sv
hdl/button_input.sv
hdl/game_fsm.sv
hdl/head_mover.sv
hdl/body_segment.sv
hdl/playfield_status.sv
hdl/snake_game_top.sv
dv/snake_checker.sv
dv/snake_game_tb.sv

// ==== dv/snake_game_tb.sv ====
//******************************
// Snake core testbench. Runs each row of the tests file through
// the UUT and has the checker compare the outcome
//******************************
`timescale 1ns/1ps

module snake_game_tb
    import snake_geometry_pkg::*, snake_control_pkg::*;
();

    logic     clock_25 = 1'b0, reset = 1'b0, game_tik = 1'b0;
    logic     right_btn = 1'b0, left_btn = 1'b0, check_strobe = 1'b0;
    coord_t   fruit_next_x = '0, fruit_next_y = '0;
    coord_t   head_x, head_y, fruit_x, fruit_y;
    score_t   score;
    length_t  snake_length;
    heading_t heading;
    logic     start, game_over;
    logic [127:0] test_name;
    logic [43:0]  expected;
    int       mismatch_count, check_count;
    int       row_count = 0, setup_errors = 0, cycle_limit = 200;   // Limit grows per row

    snake_game_top UUT (.*);
    snake_checker u_checker (.*);

    always #10 clock_25 = ~clock_25;

    // Heading that results from a queued turn of the given button code
    function automatic heading_t turned_heading(input heading_t from, input int btn);
        heading_t result;
        result = from;
        if (btn == 1) begin
            case (from)
                head_up:    result = head_right;
                head_right: result = head_down;
                head_down:  result = head_left;
                default:    result = head_up;
            endcase
        end else if (btn == 2) begin
            case (from)
                head_up:    result = head_left;
                head_right: result = head_up;
                head_down:  result = head_right;
                default:    result = head_down;
            endcase
        end
        return result;
    endfunction

    initial begin : watchdog
        int cycles;
        for (cycles = 0; cycles < cycle_limit; cycles++)
            @(posedge clock_25);
        $display("Timeout: the tests ran past %0d cycles without finishing", cycle_limit);
        $display("Result: FAILED");
        $finish;
    end

    initial begin : main_sequence
        int fd, n, btn, ticks, t;
        int v [0:9];
        logic [8*160-1:0] line_buf;
        logic [127:0] word;
        heading_t model_heading;
        int       queued_turn;
        logic     model_over;
        model_heading = head_right;
        queued_turn   = 0;
        model_over    = 1'b0;
        fd = $fopen("dv/snake_tests.dat", "r");
        if (fd == 0) begin
            $display("Error: the tests file dv/snake_tests.dat could not be opened");
            setup_errors++;
        end
        repeat (8) @(posedge clock_25);
        reset <= 1'b1;
        repeat (4) @(posedge clock_25);
        while (fd != 0 && !$feof(fd)) begin
            line_buf = '0;
            word     = '0;
            n = $fgets(line_buf, fd);
            n = $sscanf(line_buf, "%s %d %d %d %d %d %d %d %d %d %d %d %d", word, btn, ticks,
                        v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9]);
            if (n == 13) begin
                cycle_limit += (ticks + 1) * 40;
                row_count++;
                fruit_next_x <= coord_t'(v[0]);
                fruit_next_y <= coord_t'(v[1]);
                if (btn != 0) begin
                    right_btn <= btn[0];        // 1 right, 2 left, 3 both
                    left_btn  <= btn[1];
                    repeat (4) @(posedge clock_25);
                    right_btn <= 1'b0;
                    left_btn  <= 1'b0;
                    repeat (4) @(posedge clock_25);
                end
                for (t = 0; t < ticks; t++) begin
                    game_tik <= 1'b1;
                    @(posedge clock_25);
                    game_tik <= 1'b0;
                    repeat (7) @(posedge clock_25);   // Move settles within 4 cycles
                end
                // A press after game over restarts facing right, any other press queues a turn
                if (btn != 0) begin
                    if (model_over) begin
                        model_heading = head_right;
                        queued_turn   = 0;
                    end else begin
                        queued_turn = btn;
                    end
                end
                if (ticks > 0) begin
                    model_heading = turned_heading(model_heading, queued_turn);
                    queued_turn   = 0;                // First move uses the turn
                end
                model_over = v[9][0];
                test_name    <= word;
                expected     <= {coord_t'(v[2]), coord_t'(v[3]), score_t'(v[4]), length_t'(v[5]),
                                 coord_t'(v[6]), coord_t'(v[7]), model_heading,
                                 v[8][0], v[9][0]};
                check_strobe <= 1'b1;
                @(posedge clock_25);
                check_strobe <= 1'b0;
            end else if (n > 0 && word != "#") begin   // Lines opening with # are comments
                $display("Error: a line of the tests file could not be read as a test row");
                setup_errors++;
            end
        end
        if (fd != 0)
            $fclose(fd);
        repeat (4) @(posedge clock_25);
        $display("Rows %0d, checks %0d, mismatches %0d, other errors %0d",
                 row_count, check_count, mismatch_count, setup_errors);
        if (mismatch_count == 0 && setup_errors == 0 && row_count > 0 && check_count == row_count)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== dv/snake_checker.sv ====
//******************************
// Result checker. On each check strobe it compares the UUT outputs
// with the expected values of the current row and counts mismatches
//******************************
`timescale 1ns/1ps

module snake_checker
    import snake_geometry_pkg::*, snake_control_pkg::*;
(
    input  logic         clock_25,
    input  logic         check_strobe,
    input  logic [127:0] test_name,
    input  logic [43:0]  expected,    // Head x y, score, length, fruit x y, heading, start, over
    input  coord_t       head_x, head_y, fruit_x, fruit_y,
    input  score_t       score,
    input  length_t      snake_length,
    input  heading_t     heading,
    input  logic         start, game_over,
    output int           mismatch_count,
    output int           check_count
);

    initial begin
        mismatch_count = 0;
        check_count    = 0;
    end

    task automatic compare_value(input string field, input int want, input int got);
        if (want != got) begin
            mismatch_count++;
            $display("mismatch %0s %0s: expected %0d, actual %0d",
                     test_name, field, want, got);
        end
    endtask

    // Strobe arrives well after the move has settled
    always @(posedge clock_25) begin
        if (check_strobe) begin
            check_count++;
            compare_value("head_x", expected[43:37], head_x);
            compare_value("head_y", expected[36:30], head_y);
            compare_value("score", expected[29:23], score);
            compare_value("length", expected[22:18], snake_length);
            compare_value("fruit_x", expected[17:11], fruit_x);
            compare_value("fruit_y", expected[10:4], fruit_y);
            compare_value("heading", expected[3:2], heading);
            compare_value("start", expected[1], start);
            compare_value("game_over", expected[0], game_over);
        end
    end

endmodule

// ==== hdl/snake_game_top.sv ====
//******************************
// Snake game core top level. Buttons and game_tik in, head, fruit,
// score and status out. The body is a chain of segment cells
//******************************
`timescale 1ns/1ps
`include "snake_defines.svh"

module snake_game_top
    import snake_geometry_pkg::*, snake_control_pkg::*;
(
    input  logic     clock_25,
    input  logic     reset,
    input  logic     right_btn,
    input  logic     left_btn,
    input  logic     game_tik,
    input  coord_t   fruit_next_x,
    input  coord_t   fruit_next_y,
    output logic     start,
    output logic     game_over,
    output coord_t   head_x,
    output coord_t   head_y,
    output coord_t   fruit_x,
    output coord_t   fruit_y,
    output score_t   score,
    output length_t  snake_length,
    output heading_t heading
);

    logic any_press, turn_cw, turn_ccw, running;
    logic move_en, grow_en, restart;
    logic wall_hit, self_hit, fruit_eaten;
    logic [`BODY_SEGMENTS-1:0] seg_hits;
    coord_t seg_x [`BODY_SEGMENTS];
    coord_t seg_y [`BODY_SEGMENTS];

    button_input u_buttons (
        .clock_25(clock_25), .reset(reset),
        .right_btn(right_btn), .left_btn(left_btn),
        .move_en(move_en), .restart(restart), .running(running),
        .any_press(any_press), .turn_cw(turn_cw), .turn_ccw(turn_ccw)
    );

    game_fsm u_fsm (
        .clock_25(clock_25), .reset(reset),
        .any_press(any_press), .game_tik(game_tik),
        .wall_hit(wall_hit), .self_hit(self_hit), .fruit_eaten(fruit_eaten),
        .move_en(move_en), .grow_en(grow_en), .restart(restart),
        .start(start), .game_over(game_over), .running(running)
    );

    head_mover u_head (
        .clock_25(clock_25), .reset(reset),
        .move_en(move_en), .restart(restart),
        .turn_cw(turn_cw), .turn_ccw(turn_ccw),
        .head_x(head_x), .head_y(head_y), .heading(heading), .wall_hit(wall_hit)
    );

    for (genvar i = 0; i < `BODY_SEGMENTS; i++) begin : g_body
        coord_t prev_x;
        coord_t prev_y;
        if (i == 0) begin : g_first
            assign prev_x = head_x;      // First cell follows the head
            assign prev_y = head_y;
        end else begin : g_chain
            assign prev_x = seg_x[i-1];
            assign prev_y = seg_y[i-1];
        end

        body_segment #(.SEGMENT_INDEX(i)) u_segment (
            .clock_25(clock_25), .reset(reset),
            .move_en(move_en), .restart(restart),
            .prev_x(prev_x), .prev_y(prev_y),
            .head_x(head_x), .head_y(head_y), .snake_length(snake_length),
            .seg_x(seg_x[i]), .seg_y(seg_y[i]), .hit(seg_hits[i])
        );
    end

    playfield_status u_status (
        .clock_25(clock_25), .reset(reset),
        .grow_en(grow_en), .restart(restart),
        .head_x(head_x), .head_y(head_y),
        .fruit_next_x(fruit_next_x), .fruit_next_y(fruit_next_y),
        .seg_hits(seg_hits), .self_hit(self_hit), .fruit_eaten(fruit_eaten),
        .fruit_x(fruit_x), .fruit_y(fruit_y),
        .score(score), .snake_length(snake_length)
    );

endmodule

// ==== hdl/playfield_status.sv ====
//******************************
// Fruit, score and length. Detects eating and self collision
// and updates the counters after each fruit
//******************************
`timescale 1ns/1ps
`include "snake_defines.svh"

module playfield_status
    import snake_geometry_pkg::*, snake_control_pkg::*;
(
    input  logic                      clock_25,
    input  logic                      reset,
    input  logic                      grow_en,
    input  logic                      restart,
    input  coord_t                    head_x,
    input  coord_t                    head_y,
    input  coord_t                    fruit_next_x,
    input  coord_t                    fruit_next_y,
    input  logic [`BODY_SEGMENTS-1:0] seg_hits,
    output logic                      self_hit,
    output logic                      fruit_eaten,
    output coord_t                    fruit_x,
    output coord_t                    fruit_y,
    output score_t                    score,
    output length_t                   snake_length
);

    localparam length_t MAX_LENGTH   = length_t'(`BODY_SEGMENTS + 1);
    localparam length_t START_LENGTH = length_t'(`START_LENGTH);
    localparam score_t  LAST_SCORE   = score_t'(`SCORE_WRAP);
    localparam coord_t  FRUIT_X      = coord_t'(`START_FRUIT_X);
    localparam coord_t  FRUIT_Y      = coord_t'(`START_FRUIT_Y);

    assign fruit_eaten = (head_x == fruit_x) && (head_y == fruit_y);
    assign self_hit    = |seg_hits;      // Any active segment under the head

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            fruit_x      <= FRUIT_X;
            fruit_y      <= FRUIT_Y;
            score        <= '0;
            snake_length <= START_LENGTH;
        end else if (restart) begin
            fruit_x      <= FRUIT_X;
            fruit_y      <= FRUIT_Y;
            score        <= '0;
            snake_length <= START_LENGTH;
        end else if (grow_en) begin
            fruit_x <= fruit_next_x;     // New fruit from outside
            fruit_y <= fruit_next_y;
            if (score == LAST_SCORE)
                score <= '0;
            else
                score <= score + 1'b1;
            if (snake_length != MAX_LENGTH)
                snake_length <= snake_length + 1'b1;
        end
    end

endmodule

// ==== hdl/body_segment.sv ====
//******************************
// One body cell of the shift chain. Follows its predecessor on a
// move and reports when the head sits on it
//******************************
`timescale 1ns/1ps
`include "snake_defines.svh"

module body_segment
    import snake_geometry_pkg::*;
#(
    parameter int SEGMENT_INDEX = 0
) (
    input  logic    clock_25,
    input  logic    reset,
    input  logic    move_en,
    input  logic    restart,
    input  coord_t  prev_x,
    input  coord_t  prev_y,
    input  coord_t  head_x,
    input  coord_t  head_y,
    input  length_t snake_length,
    output coord_t  seg_x,
    output coord_t  seg_y,
    output logic    hit
);

    // Start body trails the head to the left, the rest is parked
    localparam bit      IN_START_BODY = (SEGMENT_INDEX < `START_LENGTH - 1);
    localparam coord_t  INIT_X = IN_START_BODY ? coord_t'(`START_HEAD_X - SEGMENT_INDEX - 1)
                                               : coord_t'(`EMPTY_COORD);
    localparam coord_t  INIT_Y = IN_START_BODY ? coord_t'(`START_HEAD_Y)
                                               : coord_t'(`EMPTY_COORD);
    localparam length_t ACTIVE_FROM = length_t'(SEGMENT_INDEX + 1);

    logic active;

    assign active = (snake_length > ACTIVE_FROM);    // Index below length - 1
    assign hit    = active && (seg_x == head_x) && (seg_y == head_y);

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            seg_x <= INIT_X;
            seg_y <= INIT_Y;
        end else if (restart) begin
            seg_x <= INIT_X;
            seg_y <= INIT_Y;
        end else if (move_en && active) begin
            seg_x <= prev_x;
            seg_y <= prev_y;
        end
    end

endmodule

// ==== hdl/head_mover.sv ====
//******************************
// Snake head. Applies the queued turn, steps one cell per move
// and flags a step that would leave the field
//******************************
`timescale 1ns/1ps
`include "snake_defines.svh"

module head_mover
    import snake_geometry_pkg::*;
(
    input  logic     clock_25,
    input  logic     reset,
    input  logic     move_en,
    input  logic     restart,
    input  logic     turn_cw,
    input  logic     turn_ccw,
    output coord_t   head_x,
    output coord_t   head_y,
    output heading_t heading,
    output logic     wall_hit
);

    localparam coord_t LAST_COL = coord_t'(`GRID_COLS - 1);
    localparam coord_t LAST_ROW = coord_t'(`GRID_ROWS - 1);
    localparam coord_t START_X  = coord_t'(`START_HEAD_X);
    localparam coord_t START_Y  = coord_t'(`START_HEAD_Y);

    heading_t next_heading;
    coord_t   step_x;
    coord_t   step_y;
    logic     blocked;     // Step would cross the border

    always_comb begin
        next_heading = heading;
        if (turn_cw && !turn_ccw)
            next_heading = heading_t'(heading + 2'd1);   // Wraps left to up
        else if (turn_ccw && !turn_cw)
            next_heading = heading_t'(heading - 2'd1);

        step_x  = head_x;
        step_y  = head_y;
        blocked = 1'b0;
        case (next_heading)
            head_up:
                if (head_y == '0)
                    blocked = 1'b1;
                else
                    step_y = head_y - 1'b1;
            head_down:
                if (head_y == LAST_ROW)
                    blocked = 1'b1;
                else
                    step_y = head_y + 1'b1;
            head_left:
                if (head_x == '0)
                    blocked = 1'b1;
                else
                    step_x = head_x - 1'b1;
            default:
                if (head_x == LAST_COL)
                    blocked = 1'b1;
                else
                    step_x = head_x + 1'b1;
        endcase
    end

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            head_x   <= START_X;
            head_y   <= START_Y;
            heading  <= head_right;
            wall_hit <= 1'b0;
        end else if (restart) begin
            head_x   <= START_X;
            head_y   <= START_Y;
            heading  <= head_right;
            wall_hit <= 1'b0;
        end else if (move_en) begin
            heading  <= next_heading;
            head_x   <= step_x;      // Unchanged when blocked
            head_y   <= step_y;
            wall_hit <= blocked;
        end
    end

endmodule

// ==== hdl/game_fsm.sv ====
//******************************
// Game sequencer. Moore FSM that orders each move, the growth
// after a fruit and the restart after game over
//******************************
`timescale 1ns/1ps

module game_fsm
    import snake_control_pkg::*;
(
    input  logic clock_25,
    input  logic reset,
    input  logic any_press,
    input  logic game_tik,
    input  logic wall_hit,
    input  logic self_hit,
    input  logic fruit_eaten,
    output logic move_en,
    output logic grow_en,
    output logic restart,
    output logic start,
    output logic game_over,
    output logic running
);

    game_state_t state;
    game_state_t next_state;

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset)
            state <= st_restart;
        else
            state <= next_state;
    end

    always_comb begin
        next_state = state;
        case (state)
            st_restart:   next_state = st_idle;
            st_idle:
                if (any_press)
                    next_state = st_wait;
            st_wait:
                if (game_tik)                    // Ticks elsewhere are ignored
                    next_state = st_moving;
            st_moving:    next_state = st_move_done;
            st_move_done:
                // Head and body have settled, check the outcome
                if (wall_hit || self_hit)
                    next_state = st_over;
                else if (fruit_eaten)
                    next_state = st_eaten;
                else
                    next_state = st_wait;
            st_eaten:     next_state = st_wait;
            st_over:
                if (any_press)
                    next_state = st_restart;
            default:      next_state = st_restart;
        endcase
    end

    // Strobes, one state each
    assign move_en   = (state == st_moving);
    assign grow_en   = (state == st_eaten);
    assign restart   = (state == st_restart);

    // Status levels
    assign game_over = (state == st_over);
    assign start     = (state == st_wait) || (state == st_moving) ||
                       (state == st_move_done) || (state == st_eaten);
    assign running   = start;    // Turns are only queued in play

endmodule

// ==== hdl/button_input.sv ====
//******************************
// Turn buttons. Synchronises both buttons, makes one pulse per press
// and keeps the requested turn until the head has moved
//******************************
`timescale 1ns/1ps

module button_input (
    input  logic clock_25,
    input  logic reset,
    input  logic right_btn,
    input  logic left_btn,
    input  logic move_en,
    input  logic restart,
    input  logic running,
    output logic any_press,
    output logic turn_cw,
    output logic turn_ccw
);

    logic [1:0] right_shifter;
    logic [1:0] left_shifter;
    logic       right_edge;     // One-cycle press pulses
    logic       left_edge;
    logic       right_edge_d;   // Same pulses a cycle later
    logic       left_edge_d;

    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            right_shifter <= 2'b00;
            left_shifter  <= 2'b00;
            right_edge    <= 1'b0;
            left_edge     <= 1'b0;
            right_edge_d  <= 1'b0;
            left_edge_d   <= 1'b0;
        end else begin
            right_shifter <= {right_shifter[0], right_btn};
            left_shifter  <= {left_shifter[0], left_btn};
            right_edge    <= right_shifter[0] & ~right_shifter[1];   // Rising edge only
            left_edge     <= left_shifter[0] & ~left_shifter[1];
            right_edge_d  <= right_edge;
            left_edge_d   <= left_edge;
        end
    end

    assign any_press = right_edge | left_edge;

    // The delayed pulse lets the press that leaves idle queue its turn too
    always_ff @(posedge clock_25 or negedge reset) begin
        if (!reset) begin
            turn_cw  <= 1'b0;
            turn_ccw <= 1'b0;
        end else if (restart) begin
            turn_cw  <= 1'b0;
            turn_ccw <= 1'b0;
        end else if (running && (right_edge_d || left_edge_d)) begin
            turn_cw  <= right_edge_d & ~left_edge_d;   // Both together cancel
            turn_ccw <= left_edge_d & ~right_edge_d;
        end else if (move_en) begin
            turn_cw  <= 1'b0;                          // Used by this move
            turn_ccw <= 1'b0;
        end
    end

endmodule

// ==== hdl/snake_control_pkg.sv ====
//******************************
// Game sequencing types. FSM states and the score counter
//******************************
package snake_control_pkg;

    typedef enum logic [2:0] {
        st_restart   = 3'd0,    // Restores the start position
        st_idle      = 3'd1,
        st_wait      = 3'd2,    // Waiting for the next game tick
        st_moving    = 3'd3,
        st_move_done = 3'd4,
        st_eaten     = 3'd5,
        st_over      = 3'd6
    } game_state_t;

    typedef logic [6:0] score_t;    // 0 to 99

endpackage

// ==== hdl/snake_geometry_pkg.sv ====
//******************************
// Types for grid positions, snake length and heading
// Imported by the modules that move or measure the snake
//******************************
package snake_geometry_pkg;

    typedef logic [6:0] coord_t;    // One grid coordinate
    typedef logic [4:0] length_t;   // Cells, head included

    // Clockwise order, so a turn is a step of +1 or -1
    typedef enum logic [1:0] {
        head_up    = 2'd0,
        head_right = 2'd1,
        head_down  = 2'd2,
        head_left  = 2'd3
    } heading_t;

endpackage

// ==== include/snake_defines.svh ====
//******************************
// Game constants for the snake core. Field size, start positions,
// body capacity and score wrap. Include it in any module that needs them
//******************************
`ifndef SNAKE_DEFINES_SVH
`define SNAKE_DEFINES_SVH

// Field size in cells
`define GRID_COLS      124
`define GRID_ROWS      81

// State of a new game
`define START_HEAD_X   8
`define START_HEAD_Y   40
`define START_LENGTH   6      // Cells, head included
`define START_FRUIT_X  18
`define START_FRUIT_Y  50

`define BODY_SEGMENTS  15     // Max length is one more than this
`define SCORE_WRAP     99     // Last score before it returns to 0
`define EMPTY_COORD    127    // Parked position of an unused segment

`endif
